//--- hdl/aluPkg.sv
/* ALU package
   Opcode constants, decoded function codes and the instruction and operation payloads */
package aluPkg;

   typedef logic [31:0] word_t;    // Operand or result word
   typedef logic [5:0]  opcode_t;  // Major opcode
   typedef logic [15:0] imm_t;     // Immediate field
   typedef logic [4:0]  regIdx_t;  // Register index
   typedef logic [4:0]  shAmt_t;   // Barrel shift distance

   // Decoded functions
   typedef enum logic [4:0] {
      ADD, ADDC, RSUB, RSUBC, CMP, CMPU,
      OR, AND, XOR, ANDN,
      SRA, SRC, SRL, SEXT8, SEXT16,
      BSRL, BSRA, BSLL,
      MFS, MTS, RTID, RTBD, TRAP_BRK, TRAP_INT,
      LDST_B, LDST_H, LDST_W, PASS
   } aluFunc_e;

   typedef struct packed {
      opcode_t opcode;
      imm_t    imm;
      regIdx_t rd;
      regIdx_t ra;
      word_t   opA;   // RA or PC
      word_t   opB;   // RB or immediate
   } instr_t;

   typedef struct packed {
      aluFunc_e func;
      word_t    opA;
      word_t    opB;
      shAmt_t   shAmt;
      logic     useCarry;  // ADDC and RSUBC forms
   } decOp_t;

   // Register-form opcodes, immediate forms set bit 3
   localparam opcode_t OPC_ADD   = 6'o00;
   localparam opcode_t OPC_RSUB  = 6'o01;
   localparam opcode_t OPC_ADDC  = 6'o02;
   localparam opcode_t OPC_RSUBC = 6'o03;
   localparam opcode_t OPC_CMP   = 6'o05;  // imm[0] set, imm[1] for unsigned
   localparam opcode_t OPC_BS    = 6'o21;
   localparam opcode_t OPC_OR    = 6'o40;
   localparam opcode_t OPC_AND   = 6'o41;
   localparam opcode_t OPC_XOR   = 6'o42;
   localparam opcode_t OPC_ANDN  = 6'o43;
   localparam opcode_t OPC_SHIFT = 6'o44;
   localparam opcode_t OPC_MSR   = 6'o45;
   localparam opcode_t OPC_BR    = 6'o46;
   localparam opcode_t OPC_RET   = 6'o55;
   localparam opcode_t OPC_BRI   = 6'o56;
   localparam opcode_t OPC_LBU   = 6'o60;
   localparam opcode_t OPC_LHU   = 6'o61;
   localparam opcode_t OPC_LW    = 6'o62;
   localparam opcode_t OPC_SB    = 6'o64;
   localparam opcode_t OPC_SH    = 6'o65;
   localparam opcode_t OPC_SW    = 6'o66;

   // Register fields that pick the special forms
   localparam regIdx_t REG_RTID = 5'h11;  // rd of return from interrupt
   localparam regIdx_t REG_RTBD = 5'h12;  // rd of return from break
   localparam regIdx_t REG_BRK  = 5'h0C;  // ra of break trap
   localparam regIdx_t REG_INT  = 5'h0E;  // ra of interrupt trap

endpackage

//--- hdl/busPkg.sv
/* Data bus package
   Bus request and result payloads, status word bit positions */
package busPkg;

   typedef logic [3:0]  byteSel_t;   // Byte lanes, MSB is byte 0
   typedef logic [29:0] wordAddr_t;  // Word address, byte offset dropped

   typedef struct packed {
      wordAddr_t addr;
      byteSel_t  sel;
      logic      req;
   } dataReq_t;

   typedef struct packed {
      aluPkg::word_t data;
      logic          carry;
      dataReq_t      bus;
   } result_t;

   // MSR layout
   localparam int MSR_BE  = 0;   // Bus lock
   localparam int MSR_IE  = 1;
   localparam int MSR_C   = 2;
   localparam int MSR_BIP = 3;
   localparam int MSR_ICE = 5;
   localparam int MSR_DCE = 7;
   localparam int MSR_CC  = 31;  // Carry copy

endpackage

//--- hdl/opIssue.sv
/* Issue stage
   Decodes incoming instructions into ALU functions, holds one entry under valid/ready */
`timescale 1ns/10ps

module opIssue (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           instrValid_i,
   input  aluPkg::instr_t instr_i,
   output logic           instrReady_o,
   output logic           issueValid_o,
   output aluPkg::decOp_t issueOp_o,
   input  logic           issueReady_i
);
   import aluPkg::*;

   aluFunc_e func;
   logic     useCarry;
   opcode_t  opc;
   imm_t     imm;
   logic     instrFire;

   assign opc = instr_i.opcode;
   assign imm = instr_i.imm;

   // Empty, or entry leaves this same cycle
   assign instrReady_o = !issueValid_o || issueReady_i;
   assign instrFire    = instrValid_i && instrReady_o;

   always_comb begin
      func     = PASS;
      useCarry = 1'b0;
      if (opc[5:4] == 2'b00) begin           // Add/sub group, both forms
         useCarry = opc[1];
         if (!opc[0])
            func = opc[1] ? ADDC : ADD;
         else if (opc[2:0] == OPC_CMP[2:0] && imm[0])
            func = imm[1] ? CMPU : CMP;
         else
            func = opc[1] ? RSUBC : RSUB;
      end else if ({opc[5:4], opc[2:0]} == {OPC_BS[5:4], OPC_BS[2:0]}) begin
         case (imm[10:9])
            2'd0:    func = BSRL;
            2'd1:    func = BSRA;
            2'd2:    func = BSLL;
            default: func = PASS;
         endcase
      end else if (opc[5:4] == 2'b10 && !opc[2]) begin  // Logic, both forms
         case (opc[1:0])
            2'd0: func = OR;
            2'd1: func = AND;
            2'd2: func = XOR;
            2'd3: func = ANDN;
         endcase
      end else if (opc == OPC_SHIFT) begin
         case (imm[6:5])
            2'd0: func = SRA;
            2'd1: func = SRC;
            2'd2: func = SRL;
            2'd3: func = imm[0] ? SEXT16 : SEXT8;
         endcase
      end else if (opc == OPC_MSR) begin
         func = imm[14] ? MTS : MFS;
      end else if (opc == OPC_RET) begin
         if (instr_i.rd == REG_RTID)
            func = RTID;
         else if (instr_i.rd == REG_RTBD)
            func = RTBD;
      end else if (opc == OPC_BR || opc == OPC_BRI) begin
         if (instr_i.ra == REG_BRK)
            func = TRAP_BRK;
         else if (instr_i.ra == REG_INT)
            func = TRAP_INT;
      end else if (opc[5:4] == 2'b11) begin  // Loads and stores
         case (opc[1:0])
            2'd0:    func = LDST_B;
            2'd1:    func = LDST_H;
            2'd2:    func = LDST_W;
            default: func = PASS;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i)
         issueValid_o <= 1'b0;
      else if (instrFire)
         issueValid_o <= 1'b1;
      else if (issueReady_i)
         issueValid_o <= 1'b0;  // Drained
   end

   // Entry payload
   always_ff @(posedge clk_i) begin
      if (instrFire) begin
         issueOp_o.func     <= func;
         issueOp_o.opA      <= instr_i.opA;
         issueOp_o.opB      <= instr_i.opB;
         issueOp_o.shAmt    <= instr_i.opB[4:0];
         issueOp_o.useCarry <= useCarry;
      end
   end

endmodule

//--- hdl/arithLogic.sv
/* Arithmetic and logic datapath
   Combinational result and carry for every decoded function */
`timescale 1ns/10ps

module arithLogic #(
   parameter int HAS_BARREL = 1
) (
   input  aluPkg::decOp_t op_i,
   input  logic           carry_i,
   input  aluPkg::word_t  statusWord_i,
   output aluPkg::word_t  result_o,
   output logic           carry_o
);
   import aluPkg::*;

   localparam bit BARREL_ON = (HAS_BARREL != 0);

   logic  subtract;       // Reverse subtract and compares
   logic  carryIn;
   word_t addX;           // opA or its complement
   word_t sum;
   logic  sumCarry;
   logic  gtSigned, gtUnsigned;
   word_t bsrl, bsra, bsll;

   assign subtract = (op_i.func inside {RSUB, RSUBC, CMP, CMPU});
   assign addX     = subtract ? ~op_i.opA : op_i.opA;
   assign carryIn  = op_i.useCarry ? carry_i : subtract;  // +1 completes two's complement

   // One adder serves add, sub, compare and address sums
   assign {sumCarry, sum} = {1'b0, op_i.opB} + {1'b0, addX} + {32'd0, carryIn};

   assign gtSigned   = $signed(op_i.opA) > $signed(op_i.opB);
   assign gtUnsigned = op_i.opA > op_i.opB;

   // Barrel shifter, zero when not fitted
   assign bsrl = BARREL_ON ? (op_i.opA >> op_i.shAmt) : '0;
   assign bsra = BARREL_ON ? word_t'($signed(op_i.opA) >>> op_i.shAmt) : '0;
   assign bsll = BARREL_ON ? (op_i.opA << op_i.shAmt) : '0;

   always_comb begin
      result_o = op_i.opA;   // Moves, traps and pass-through
      carry_o  = carry_i;    // Kept unless written below
      case (op_i.func)
         ADD, ADDC, RSUB, RSUBC: begin
            result_o = sum;
            carry_o  = sumCarry;  // Set means no borrow on subtract
         end
         CMP:  result_o = {gtSigned, sum[30:0]};
         CMPU: result_o = {gtUnsigned, sum[30:0]};
         OR:   result_o = op_i.opA | op_i.opB;
         AND:  result_o = op_i.opA & op_i.opB;
         XOR:  result_o = op_i.opA ^ op_i.opB;
         ANDN: result_o = op_i.opA & ~op_i.opB;
         SRA: begin
            result_o = {op_i.opA[31], op_i.opA[31:1]};
            carry_o  = op_i.opA[0];
         end
         SRC: begin
            result_o = {carry_i, op_i.opA[31:1]};   // Rotate through carry
            carry_o  = op_i.opA[0];
         end
         SRL: begin
            result_o = {1'b0, op_i.opA[31:1]};
            carry_o  = op_i.opA[0];
         end
         SEXT8:  result_o = {{24{op_i.opA[7]}}, op_i.opA[7:0]};
         SEXT16: result_o = {{16{op_i.opA[15]}}, op_i.opA[15:0]};
         BSRL:   result_o = bsrl;
         BSRA:   result_o = bsra;
         BSLL:   result_o = bsll;
         MFS:    result_o = statusWord_i;
         // Return target and memory address
         RTID, RTBD, LDST_B, LDST_H, LDST_W: result_o = sum;
         default: ;
      endcase
   end

endmodule

//--- hdl/statusReg.sv
/* Machine status register
   Carry, IE, BIP, BE and cache enables, updated per completed operation */
`timescale 1ns/10ps

module statusReg (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           update_i,
   input  aluPkg::decOp_t op_i,
   input  logic           carryNew_i,
   output logic           carry_o,
   output aluPkg::word_t  statusWord_o
);
   import aluPkg::*;
   import busPkg::*;

   logic msrBe, msrIe, msrBip, msrIce, msrDce;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         carry_o <= 1'b0;
         msrBe   <= 1'b0;
         msrIe   <= 1'b0;
         msrBip  <= 1'b0;
         msrIce  <= 1'b0;
         msrDce  <= 1'b0;
      end else if (update_i) begin
         carry_o <= carryNew_i;
         case (op_i.func)
            MTS: begin
               carry_o <= op_i.opA[MSR_C];  // Move-to overrides datapath carry
               msrBe   <= op_i.opA[MSR_BE];
               msrIe   <= op_i.opA[MSR_IE];
               msrBip  <= op_i.opA[MSR_BIP];
               msrIce  <= op_i.opA[MSR_ICE];
               msrDce  <= op_i.opA[MSR_DCE];
            end
            RTID:     msrIe  <= 1'b1;
            RTBD:     msrBip <= 1'b0;
            TRAP_INT: msrIe  <= 1'b0;  // Nested interrupts masked
            TRAP_BRK: msrBip <= 1'b1;
            default: ;
         endcase
      end
   end

   // Unused bits read as zero
   always_comb begin
      statusWord_o          = '0;
      statusWord_o[MSR_BE]  = msrBe;
      statusWord_o[MSR_IE]  = msrIe;
      statusWord_o[MSR_C]   = carry_o;
      statusWord_o[MSR_BIP] = msrBip;
      statusWord_o[MSR_ICE] = msrIce;
      statusWord_o[MSR_DCE] = msrDce;
      statusWord_o[MSR_CC]  = carry_o;
   end

endmodule

//--- hdl/resultStage.sv
/* Result stage
   Registers result, carry and data bus request under valid/ready */
`timescale 1ns/10ps

module resultStage #(
   parameter int DATA_ADDR_W = 32
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              acceptValid_i,
   input  aluPkg::aluFunc_e  func_i,
   input  aluPkg::word_t     result_i,
   input  logic              carry_i,
   output logic              acceptReady_o,
   output logic              resValid_o,
   output busPkg::result_t   res_o,
   input  logic              resReady_i
);
   import aluPkg::*;
   import busPkg::*;

   // Word address bits that exist on the bus
   localparam wordAddr_t ADDR_MASK = wordAddr_t'((64'd1 << (DATA_ADDR_W - 2)) - 64'd1);

   dataReq_t reqNext;
   logic     acceptFire;

   assign acceptReady_o = !resValid_o || resReady_i;
   assign acceptFire    = acceptValid_i && acceptReady_o;

   always_comb begin
      reqNext = '0;  // Non-memory ops issue no request
      if (func_i inside {LDST_B, LDST_H, LDST_W}) begin
         reqNext.req  = 1'b1;
         reqNext.addr = result_i[31:2] & ADDR_MASK;
      end
      case (func_i)
         LDST_B:
            case (result_i[1:0])  // Big-endian lanes
               2'd0: reqNext.sel = 4'h8;
               2'd1: reqNext.sel = 4'h4;
               2'd2: reqNext.sel = 4'h2;
               2'd3: reqNext.sel = 4'h1;
            endcase
         LDST_H:  reqNext.sel = result_i[1] ? 4'h3 : 4'hC;
         LDST_W:  reqNext.sel = 4'hF;
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i)
         resValid_o <= 1'b0;
      else if (acceptFire)
         resValid_o <= 1'b1;
      else if (resReady_i)
         resValid_o <= 1'b0;
   end

   always_ff @(posedge clk_i) begin
      if (acceptFire) begin
         res_o.data  <= result_i;
         res_o.carry <= carry_i;   // Carry after this op
         res_o.bus   <= reqNext;
      end
   end

endmodule

//--- hdl/execUnit.sv
/* Integer execute unit
   Issue register, ALU datapath, status register and result register */
`timescale 1ns/10ps

module execUnit #(
   parameter int HAS_BARREL  = 1,
   parameter int DATA_ADDR_W = 32
) (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            instrValid_i,
   input  aluPkg::instr_t  instr_i,
   output logic            instrReady_o,
   output logic            resValid_o,
   output busPkg::result_t res_o,
   input  logic            resReady_i
);
   import aluPkg::*;

   logic   issueValid, acceptReady;
   logic   issueFire;              // Op moves into result register
   decOp_t issueOp;
   word_t  aluResult, statusWord;
   logic   aluCarry, carry;

   assign issueFire = issueValid & acceptReady;

   opIssue opIssue_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .instrValid_i (instrValid_i),
      .instr_i      (instr_i),
      .instrReady_o (instrReady_o),
      .issueValid_o (issueValid),
      .issueOp_o    (issueOp),
      .issueReady_i (acceptReady)
   );

   arithLogic #(.HAS_BARREL(HAS_BARREL)) arithLogic_i (
      .op_i         (issueOp),
      .carry_i      (carry),
      .statusWord_i (statusWord),
      .result_o     (aluResult),
      .carry_o      (aluCarry)
   );

   statusReg statusReg_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .update_i     (issueFire),
      .op_i         (issueOp),
      .carryNew_i   (aluCarry),
      .carry_o      (carry),
      .statusWord_o (statusWord)
   );

   resultStage #(.DATA_ADDR_W(DATA_ADDR_W)) resultStage_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .acceptValid_i (issueValid),
      .func_i        (issueOp.func),
      .result_i      (aluResult),
      .carry_i       (aluCarry),
      .acceptReady_o (acceptReady),
      .resValid_o    (resValid_o),
      .res_o         (res_o),
      .resReady_i    (resReady_i)
   );

endmodule

//--- verif/execUnit_props.sv
/* Execute unit handshake properties
   Reset state, output hold under stall and two-cycle latency */
`timescale 1ns/10ps

module execUnit_props (
   input logic            clk_i,
   input logic            rst_i,
   input logic            instrValid_i,
   input logic            instrReady_i,
   input logic            issueValid_i,   // Issue register occupied
   input logic            resValid_i,
   input busPkg::result_t res_i,
   input logic            resReady_i
);
   int failCount = 0;

   // Both registers empty once reset has been seen
   resetState: assert property (@(posedge clk_i) rst_i |=> instrReady_i && !resValid_i)
      else begin
         $error("Pipeline not empty after reset");
         failCount++;
      end

   // Stalled output holds
   holdOnStall: assert property (@(posedge clk_i) disable iff (rst_i)
      resValid_i && !resReady_i |=> resValid_i && $stable(res_i))
      else begin
         $error("Result changed while stalled");
         failCount++;
      end

   // Two edges from input transfer to output valid on an empty pipeline
   latency: assert property (@(posedge clk_i) disable iff (rst_i)
      instrValid_i && instrReady_i && !issueValid_i && !resValid_i |-> ##2 $rose(resValid_i))
      else begin
         $error("Result latency is not two cycles");
         failCount++;
      end

endmodule

bind execUnit execUnit_props props_i (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .instrValid_i (instrValid_i),
   .instrReady_i (instrReady_o),
   .issueValid_i (issueValid),
   .resValid_i   (resValid_o),
   .res_i        (res_o),
   .resReady_i   (resReady_i)
);

//--- verif/execUnit_tb.sv
/* Execute unit testbench
   Directed and random instructions checked against an in-order reference model */
`timescale 1ns/10ps

module execUnit_tb;
   import aluPkg::*;
   import busPkg::*;

   localparam int TMO = 200;   // Cycles allowed per wait

   logic        clk_i = 1'b0;
   logic        rst_i, instrValid_i, instrReady_o, resValid_o;
   logic        resReady_i = 1'b1;
   instr_t      instr_i;
   result_t     res_o, expected;
   result_t     expQ[$];                  // Reference results with the oldest first
   logic [31:0] instrSeed = 32'h41f7;
   logic [31:0] stallSeed = 32'h41f7;
   logic        mC, mBe, mIe, mBip, mIce, mDce;  // Model status bits
   logic        stallMode, timedOut;
   int          resErrors = 0;
   int          readyErrors = 0;
   int          streamErrors = 0;
   int          outCount = 0;
   int          streamBase = -1;
   int          firstCyc, lastCyc;
   int          cycle = 0;
   aluFunc_e    dirSeq[10] = '{MTS, MFS, TRAP_INT, MFS, RTID, MFS, RTBD, MFS, TRAP_BRK, MFS};

   execUnit execUnit_i (.*);

   always #50 clk_i = ~clk_i;
   always @(posedge clk_i) cycle <= cycle + 1;

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Random output back-pressure
   always @(negedge clk_i) begin
      stallSeed = lcg(stallSeed);
      resReady_i = stallMode ? stallSeed[30] : 1'b1;
   end

   // Instruction word for a function where alt picks store or immediate forms
   function automatic instr_t encode(input aluFunc_e f, input word_t a, input word_t b,
                                     input logic alt);
      instr_t i;
      i     = '0;
      i.opA = a;
      i.opB = b;
      case (f)
         ADD:                          i.opcode = OPC_ADD;
         ADDC:                         i.opcode = OPC_ADDC;
         RSUB:                         i.opcode = OPC_RSUB;
         RSUBC:                        i.opcode = OPC_RSUBC;
         CMP, CMPU:                    i.opcode = OPC_CMP;
         OR:                           i.opcode = OPC_OR;
         AND:                          i.opcode = OPC_AND;
         XOR:                          i.opcode = OPC_XOR;
         ANDN:                         i.opcode = OPC_ANDN;
         SRA, SRC, SRL, SEXT8, SEXT16: i.opcode = OPC_SHIFT;
         BSRL, BSRA, BSLL:             i.opcode = OPC_BS;
         MFS, MTS:                     i.opcode = OPC_MSR;
         RTID, RTBD:                   i.opcode = OPC_RET;
         TRAP_BRK, TRAP_INT:           i.opcode = alt ? OPC_BR : OPC_BRI;
         LDST_B:                       i.opcode = alt ? OPC_SB : OPC_LBU;
         LDST_H:                       i.opcode = alt ? OPC_SH : OPC_LHU;
         default:                      i.opcode = alt ? OPC_SW : OPC_LW;
      endcase
      if (f inside {ADD, ADDC, RSUB, RSUBC, CMP, CMPU, OR, AND, XOR, ANDN})
         i.opcode[3] = alt;              // Immediate form
      case (f)
         CMP:     i.imm = 16'h0001;
         CMPU:    i.imm = 16'h0003;
         SRC:     i.imm = 16'h0020;      // imm[6:5] shift kind
         SRL:     i.imm = 16'h0040;
         SEXT8:   i.imm = 16'h0060;
         SEXT16:  i.imm = 16'h0061;
         BSRA:    i.imm = 16'h0200;      // imm[10:9] barrel kind
         BSLL:    i.imm = 16'h0400;
         MTS:     i.imm = 16'h4000;
         default: ;
      endcase
      i.rd = (f == RTBD) ? REG_RTBD : REG_RTID;
      i.ra = (f == TRAP_INT) ? REG_INT : REG_BRK;
      return i;
   endfunction

   // Reference rules applied in input order
   task automatic modelStep(input aluFunc_e f, input word_t a, input word_t b,
                            output result_t r);
      logic [32:0] addSum, subSum;
      word_t       sw;
      sw     = {mC, 23'd0, mDce, 1'b0, mIce, 1'b0, mBip, mC, mIe, mBe};
      addSum = {1'b0, a} + {1'b0, b} + {32'd0, f == ADDC && mC};
      subSum = {1'b0, b} + {1'b0, ~a} + {32'd0, (f == RSUBC) ? mC : 1'b1};
      r       = '0;
      r.carry = mC;                      // Kept unless written
      r.data  = a;                       // Moves and traps pass opA
      case (f)
         ADD, ADDC, RTID, RTBD, LDST_B, LDST_H, LDST_W: r.data = addSum[31:0];
         RSUB, RSUBC: r.data = subSum[31:0];
         CMP:         r.data = {$signed(a) > $signed(b), subSum[30:0]};
         CMPU:        r.data = {a > b, subSum[30:0]};
         OR:          r.data = a | b;
         AND:         r.data = a & b;
         XOR:         r.data = a ^ b;
         ANDN:        r.data = a & ~b;
         SRA:         r.data = {a[31], a[31:1]};
         SRC:         r.data = {mC, a[31:1]};
         SRL:         r.data = {1'b0, a[31:1]};
         SEXT8:       r.data = {{24{a[7]}}, a[7:0]};
         SEXT16:      r.data = {{16{a[15]}}, a[15:0]};
         BSRL:        r.data = a >> b[4:0];
         BSRA:        r.data = $signed(a) >>> b[4:0];
         BSLL:        r.data = a << b[4:0];
         MFS:         r.data = sw;
         default: ;
      endcase
      if (f inside {ADD, ADDC})
         r.carry = addSum[32];
      if (f inside {RSUB, RSUBC})
         r.carry = subSum[32];           // Set when no borrow
      if (f inside {SRA, SRC, SRL})
         r.carry = a[0];                 // Bit shifted out
      if (f inside {LDST_B, LDST_H, LDST_W}) begin
         r.bus.req  = 1'b1;
         r.bus.addr = addSum[31:2];
         if (f == LDST_W)
            r.bus.sel = 4'hF;
         else if (f == LDST_H)
            r.bus.sel = addSum[1] ? 4'h3 : 4'hC;
         else
            r.bus.sel = 4'h8 >> addSum[1:0];  // Byte 0 on the top lane
      end
      mC = r.carry;
      case (f)
         MTS: begin
            mC   = a[MSR_C];             // Written carry wins
            mBe  = a[MSR_BE];
            mIe  = a[MSR_IE];
            mBip = a[MSR_BIP];
            mIce = a[MSR_ICE];
            mDce = a[MSR_DCE];
         end
         RTID:     mIe  = 1'b1;
         RTBD:     mBip = 1'b0;
         TRAP_INT: mIe  = 1'b0;
         TRAP_BRK: mBip = 1'b1;
         default: ;
      endcase
   endtask

   // One instruction through the input handshake
   task automatic sendInstr(input aluFunc_e f, input word_t a, input word_t b,
                            input logic alt);
      result_t r;
      int      n;
      if (timedOut)
         return;
      @(negedge clk_i);
      instr_i      = encode(f, a, b, alt);
      instrValid_i = 1'b1;
      n = 0;
      do begin
         @(posedge clk_i);
         n++;
      end while (!instrReady_o && n < TMO);
      if (instrReady_o) begin
         modelStep(f, a, b, r);          // Accepted on this edge
         expQ.push_back(r);
      end else begin
         timedOut = 1'b1;
         $display("Timeout: instrReady_o stayed low for %0d cycles", TMO);
      end
   endtask

   task automatic idle();
      @(negedge clk_i);
      instrValid_i = 1'b0;
   endtask

   // Wait until every accepted instruction has come out
   task automatic drain();
      int n;
      n = 0;
      while (expQ.size() != 0 && n < TMO) begin
         @(negedge clk_i);
         n++;
      end
      if (expQ.size() != 0 && !timedOut) begin
         timedOut = 1'b1;
         $display("Timeout: %0d results never came out", expQ.size());
      end
   endtask

   task automatic randomInstr();
      aluFunc_e f;
      word_t    a, b;
      instrSeed = lcg(instrSeed);
      f = aluFunc_e'(5'(instrSeed[31:24] % 8'd27));   // Anything but PASS
      instrSeed = lcg(instrSeed);
      a = (instrSeed[31:28] == 4'd0) ? 32'hFFFF_FFFF : instrSeed;  // Forces carry chains
      instrSeed = lcg(instrSeed);
      b = {instrSeed[15:0], instrSeed[31:16]};
      sendInstr(f, a, b, instrSeed[13]);
   endtask

   // Output check against the model queue
   always @(posedge clk_i) begin
      if (!rst_i) begin
         // Input stalls only with two unread results held
         assert (instrReady_o || (expQ.size() == 2 && !resReady_i)) else begin
            readyErrors++;
            $display("FAIL %0t: input not ready with %0d results in flight", $time,
                     expQ.size());
         end
      end
      if (!rst_i && resValid_o && resReady_i) begin
         assert (expQ.size() != 0) else begin
            resErrors++;
            $display("FAIL %0t: result with no instruction outstanding", $time);
         end
         if (expQ.size() != 0) begin
            expected = expQ.pop_front();
            assert (res_o == expected) else begin
               resErrors++;
               $display("FAIL %0t: result %h, expected %h", $time, res_o, expected);
            end
         end
         if (outCount == streamBase)
            firstCyc = cycle;
         lastCyc = cycle;
         outCount++;
      end
   end

   initial begin
      rst_i        = 1'b1;
      instrValid_i = 1'b0;
      instr_i      = '0;
      stallMode    = 1'b0;
      timedOut     = 1'b0;
      {mC, mBe, mIe, mBip, mIce, mDce} = '0;   // Matches reset state
      repeat (4) @(negedge clk_i);
      rst_i = 1'b0;
      // Status moves, returns and traps
      foreach (dirSeq[k])
         sendInstr(dirSeq[k], 32'h0000_00AF ^ 32'(k), '0, k[0]);
      for (int k = 0; k < 8; k++)
         sendInstr(aluFunc_e'(k[0] ? RSUBC : ADDC), 32'hFFFF_FFFF, 32'(k), 1'b0);
      // Random mix under stalls
      stallMode = 1'b1;
      for (int k = 0; k < 300; k++) begin
         randomInstr();
         if (instrSeed[7:5] == 3'd0)
            idle();                      // Gap in the input stream
      end
      idle();
      drain();
      stallMode = 1'b0;
      // Back to back at full throughput
      streamBase = outCount;
      for (int k = 0; k < 16; k++)
         sendInstr(ADD, 32'(k), 32'h100, 1'b1);
      idle();
      drain();
      assert (outCount - streamBase == 16 && lastCyc - firstCyc == 15) else begin
         streamErrors++;
         $display("FAIL %0t: 16 streamed results took %0d cycles", $time,
                  lastCyc - firstCyc + 1);
      end
      $display({"Results: %0d, mismatches: %0d, ready errors: %0d, stream errors: %0d, ",
                "assertion failures: %0d"}, outCount, resErrors, readyErrors, streamErrors,
               execUnit_i.props_i.failCount);
      if (resErrors == 0 && readyErrors == 0 && streamErrors == 0 && !timedOut &&
          execUnit_i.props_i.failCount == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- verilog.f
hdl/aluPkg.sv
hdl/busPkg.sv
hdl/opIssue.sv
hdl/arithLogic.sv
hdl/statusReg.sv
hdl/resultStage.sv
hdl/execUnit.sv
verif/execUnit_props.sv
verif/execUnit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/10ps \
   --top-module execUnit_tb -o execUnit_sim -f verilog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/execUnit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
   exit 0
fi
exit 1
